//--- source/softmax_pkg.sv
// Softmax engine package with the shared widths, data types and divider latency
`default_nettype none

package softmax_pkg;

  // Field widths
  localparam int COEF_W     = 4;
  localparam int EXP_W      = 16;
  localparam int SUM_W      = 19;
  localparam int ALPHA_W    = 16;
  localparam int NODE_CNT_W = 4;
  localparam int SG_ADDR_W  = 6;

  // Defaults for the top level
  localparam int MAX_NODES     = 8;
  localparam int NUM_SUBGRAPHS = 64;

  // One quotient bit per stage plus the operand register
  localparam int DIV_LATENCY = ALPHA_W + 1;

  typedef logic [COEF_W-1:0]     coef_t;
  typedef logic [EXP_W-1:0]      exp_t;
  typedef logic [SUM_W-1:0]      sum_t;
  typedef logic [ALPHA_W-1:0]    alpha_t;   // Unsigned Q1.15
  typedef logic [NODE_CNT_W-1:0] node_cnt_t;
  typedef logic [SG_ADDR_W-1:0]  sg_addr_t;

endpackage

`default_nettype wire

//--- source/fifo_if.sv
// FIFO interface carrying data, push/pop strobes, full/empty flags and fill level
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
  parameter type data_t = logic [7:0],
  parameter int  DEPTH  = 16
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            data_in;
  logic             push;
  logic             pop;
  data_t            data_out;
  logic             full;
  logic             empty;
  logic [CNT_W-1:0] count;

  modport producer (output data_in, output push, input full, input count);
  modport consumer (output pop, input data_out, input empty);
  modport fifo (
    input  data_in, push, pop,
    output data_out, full, empty, count
  );

endinterface

`default_nettype wire

//--- source/sync_fifo.sv
// Synchronous FIFO on a circular buffer with a fill count
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type data_t     = logic [7:0],
  parameter int  FIFO_DEPTH = 16
) (
  input  logic clk,
  input  logic rst_n,
  fifo_if.fifo f
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  data_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (f.push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (f.pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({f.push, f.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (f.push) begin
      mem[wr_ptr] <= f.data_in;
    end
  end

  // Head entry is visible while not empty
  assign f.data_out = mem[rd_ptr];
  assign f.full     = (count_q == CNT_W'(FIFO_DEPTH));
  assign f.empty    = (count_q == '0);
  assign f.count    = count_q;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) f.push |-> !f.full)
    else $error("sync_fifo: push while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) f.pop |-> !f.empty)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

//--- source/node_count_ram.sv
// Node-count table, one entry per subgraph, host written and read asynchronously
`timescale 1ns/1ps
`default_nettype none

module node_count_ram #(
  parameter int DEPTH = softmax_pkg::NUM_SUBGRAPHS
) (
  input  logic                   clk,
  input  logic                   wr_en,
  input  softmax_pkg::sg_addr_t  wr_addr,
  input  softmax_pkg::node_cnt_t wr_data,
  input  softmax_pkg::sg_addr_t  rd_addr,
  output softmax_pkg::node_cnt_t rd_data
);

  softmax_pkg::node_cnt_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_addr];

  // A zero count would never close its subgraph in the engine
  a_no_zero_count: assert property (@(posedge clk) wr_en |-> (wr_data != '0))
    else $error("node_count_ram: zero node count written");

endmodule

`default_nettype wire

//--- source/fxp_div_pipe.sv
// Pipelined restoring divider giving floor(dividend * 2^15 / divisor) in Q1.15
`timescale 1ns/1ps
`default_nettype none

module fxp_div_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                div_vld,
  input  softmax_pkg::exp_t   dividend,
  input  softmax_pkg::sum_t   divisor,
  output logic                div_rdy,
  output softmax_pkg::alpha_t quotient
);

  localparam int QW   = $bits(softmax_pkg::alpha_t);
  localparam int NSTG = softmax_pkg::DIV_LATENCY - 1;
  localparam int RW   = $bits(softmax_pkg::sum_t) + 1;

  // Stage 0 is the operand register, stage k holds k quotient bits
  logic [RW-1:0]       rem_q  [NSTG+1];
  softmax_pkg::sum_t   dvsr_q [NSTG+1];
  softmax_pkg::alpha_t quo_q  [NSTG+1];
  logic [NSTG:0]       vld_q;

  logic [NSTG-1:0]     ge;
  logic [RW-1:0]       rem_nxt [NSTG];

  // ==================
  // Per-stage compare and restore
  // ==================
  always_comb begin
    for (int k = 0; k < NSTG; k++) begin
      ge[k]      = (rem_q[k] >= RW'(dvsr_q[k]));
      rem_nxt[k] = ge[k] ? (rem_q[k] - RW'(dvsr_q[k])) : rem_q[k];
    end
  end

  // Remainder stays below the divisor, so the shift never loses a set bit
  always_ff @(posedge clk) begin
    rem_q[0]  <= RW'(dividend);
    dvsr_q[0] <= divisor;
    quo_q[0]  <= '0;
    for (int k = 0; k < NSTG; k++) begin
      rem_q[k+1]  <= {rem_nxt[k][RW-2:0], 1'b0};
      dvsr_q[k+1] <= dvsr_q[k];
      quo_q[k+1]  <= {quo_q[k][QW-2:0], ge[k]};
    end
  end

  // Valid bit travels beside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[NSTG-1:0], div_vld};
    end
  end

  assign div_rdy  = vld_q[NSTG];
  assign quotient = quo_q[NSTG];

  // Quotient must stay within Q1.15, so dividend cannot exceed divisor
  a_div_operands: assert property (@(posedge clk) disable iff (!rst_n)
      div_vld |-> (divisor != '0) && (divisor >= softmax_pkg::sum_t'(dividend)))
    else $error("fxp_div_pipe: divisor zero or below dividend");

endmodule

`default_nettype wire

//--- source/softmax.sv
// Softmax engine: forms 2^e, sums each subgraph and divides every term by its sum
`timescale 1ns/1ps
`default_nettype none

module softmax #(
  parameter int MAX_NODES  = softmax_pkg::MAX_NODES,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sm_en,
  fifo_if.consumer               coef,
  fifo_if.producer               alpha,
  output softmax_pkg::sg_addr_t  sg_addr,
  input  softmax_pkg::node_cnt_t node_count
);

  localparam int STAGE_DEPTH = 2 * MAX_NODES;
  localparam int FLT_W       = $clog2(softmax_pkg::DIV_LATENCY + 2);
  localparam int CRED_W      = $clog2(FIFO_DEPTH + softmax_pkg::DIV_LATENCY + 2);
  localparam int WORD_W      = $bits(softmax_pkg::node_cnt_t) + $bits(softmax_pkg::sum_t);

  // Divisor FIFO entry is {node count, sum}
  typedef logic [WORD_W-1:0] dvsr_word_t;

  logic                   coef_pop;
  logic                   last_node;
  softmax_pkg::exp_t      exp_val;
  softmax_pkg::node_cnt_t node_idx;
  softmax_pkg::sum_t      sum_q;
  softmax_pkg::node_cnt_t sg_cnt_q;
  logic                   dvsr_push_q;

  logic                   take;
  logic                   first_div;
  logic                   credit_ok;
  softmax_pkg::node_cnt_t head_cnt;
  softmax_pkg::sum_t      head_sum;
  softmax_pkg::node_cnt_t div_idx;
  softmax_pkg::node_cnt_t div_num;
  softmax_pkg::node_cnt_t div_num_q;
  softmax_pkg::sum_t      dvsr_cur;
  logic                   div_vld;
  softmax_pkg::exp_t      div_dividend;
  softmax_pkg::sum_t      div_divisor;
  logic                   div_rdy;
  softmax_pkg::alpha_t    quotient;
  logic [FLT_W-1:0]       in_flight;
  logic [CRED_W-1:0]      used_slots;

  fifo_if #(.data_t(softmax_pkg::exp_t), .DEPTH(STAGE_DEPTH)) divd_if ();
  fifo_if #(.data_t(dvsr_word_t), .DEPTH(STAGE_DEPTH)) dvsr_if ();

  sync_fifo #(.data_t(softmax_pkg::exp_t), .FIFO_DEPTH(STAGE_DEPTH)) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (divd_if.fifo)
  );

  sync_fifo #(.data_t(dvsr_word_t), .FIFO_DEPTH(STAGE_DEPTH)) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (dvsr_if.fifo)
  );

  // ====================
  // Exp and sum
  // ====================
  assign exp_val   = softmax_pkg::exp_t'(1) << coef.data_out;
  assign coef_pop  = sm_en && !coef.empty && !divd_if.full;
  assign last_node = (node_idx == node_count - 1'b1);
  assign coef.pop  = coef_pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_idx    <= '0;
      sg_addr     <= '0;
      dvsr_push_q <= 1'b0;
    end else begin
      dvsr_push_q <= coef_pop && last_node;
      if (coef_pop) begin
        if (last_node) begin
          node_idx <= '0;
          sg_addr  <= sg_addr + 1'b1;
        end else begin
          node_idx <= node_idx + 1'b1;
        end
      end
    end
  end

  // First node restarts the sum
  always_ff @(posedge clk) begin
    if (coef_pop) begin
      sum_q    <= (node_idx == '0) ? softmax_pkg::sum_t'(exp_val)
                                   : sum_q + softmax_pkg::sum_t'(exp_val);
      sg_cnt_q <= node_count;
    end
  end

  assign divd_if.data_in = exp_val;
  assign divd_if.push    = coef_pop;
  assign dvsr_if.data_in = {sg_cnt_q, sum_q};
  assign dvsr_if.push    = dvsr_push_q;

  // ====================
  // Division issue
  // ====================
  assign {head_cnt, head_sum} = dvsr_if.data_out;
  assign first_div = (div_idx == '0);
  assign div_num   = first_div ? head_cnt : div_num_q;
  assign dvsr_cur  = first_div ? head_sum : div_divisor;

  // Each division in flight holds a slot in the alpha FIFO
  assign used_slots = CRED_W'(alpha.count) + CRED_W'(in_flight);
  assign credit_ok  = (used_slots < CRED_W'(FIFO_DEPTH));
  assign take       = !divd_if.empty && (!first_div || !dvsr_if.empty) && credit_ok;

  assign divd_if.pop = take;
  assign dvsr_if.pop = take && first_div;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_idx   <= '0;
      div_vld   <= 1'b0;
      in_flight <= '0;
    end else begin
      div_vld <= take;
      if (take) begin
        div_idx <= (div_idx == div_num - 1'b1) ? '0 : div_idx + 1'b1;
      end
      case ({take, div_rdy})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Operands for the divider, divisor held for the rest of the subgraph
  always_ff @(posedge clk) begin
    if (take) begin
      div_dividend <= divd_if.data_out;
      div_divisor  <= dvsr_cur;
      div_num_q    <= div_num;
    end
  end

  fxp_div_pipe u_fxp_div_pipe (
    .clk      (clk),
    .rst_n    (rst_n),
    .div_vld  (div_vld),
    .dividend (div_dividend),
    .divisor  (div_divisor),
    .div_rdy  (div_rdy),
    .quotient (quotient)
  );

  assign alpha.data_in = quotient;
  assign alpha.push    = div_rdy;

  // Credit reserved at issue guarantees room when the result lands
  a_alpha_room: assert property (@(posedge clk) disable iff (!rst_n) div_rdy |-> !alpha.full)
    else $error("softmax: alpha result with output FIFO full");

endmodule

`default_nettype wire

//--- source/softmax_top.sv
// Softmax top level with input FIFO, node-count table, engine and output FIFO
`timescale 1ns/1ps
`default_nettype none

module softmax_top #(
  parameter int FIFO_DEPTH    = 16,
  parameter int MAX_NODES     = softmax_pkg::MAX_NODES,
  parameter int NUM_SUBGRAPHS = softmax_pkg::NUM_SUBGRAPHS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sm_en,
  input  softmax_pkg::coef_t     coef_in,
  input  logic                   coef_push,
  output logic                   coef_full,
  input  logic                   num_node_wr,
  input  softmax_pkg::sg_addr_t  num_node_waddr,
  input  softmax_pkg::node_cnt_t num_node_wdata,
  output softmax_pkg::alpha_t    alpha_out,
  output logic                   alpha_empty,
  input  logic                   alpha_pop
);

  softmax_pkg::sg_addr_t  sg_addr;
  softmax_pkg::node_cnt_t node_count;

  fifo_if #(.data_t(softmax_pkg::coef_t), .DEPTH(FIFO_DEPTH)) coef_fifo_if ();
  fifo_if #(.data_t(softmax_pkg::alpha_t), .DEPTH(FIFO_DEPTH)) alpha_fifo_if ();

  // Host side of both FIFOs
  assign coef_fifo_if.data_in = coef_in;
  assign coef_fifo_if.push    = coef_push;
  assign coef_full            = coef_fifo_if.full;
  assign alpha_fifo_if.pop    = alpha_pop;
  assign alpha_out            = alpha_fifo_if.data_out;
  assign alpha_empty          = alpha_fifo_if.empty;

  sync_fifo #(.data_t(softmax_pkg::coef_t), .FIFO_DEPTH(FIFO_DEPTH)) u_coef_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (coef_fifo_if.fifo)
  );

  node_count_ram #(.DEPTH(NUM_SUBGRAPHS)) u_node_count_ram (
    .clk     (clk),
    .wr_en   (num_node_wr),
    .wr_addr (num_node_waddr),
    .wr_data (num_node_wdata),
    .rd_addr (sg_addr),
    .rd_data (node_count)
  );

  softmax #(.MAX_NODES(MAX_NODES), .FIFO_DEPTH(FIFO_DEPTH)) u_softmax (
    .clk        (clk),
    .rst_n      (rst_n),
    .sm_en      (sm_en),
    .coef       (coef_fifo_if.consumer),
    .alpha      (alpha_fifo_if.producer),
    .sg_addr    (sg_addr),
    .node_count (node_count)
  );

  sync_fifo #(.data_t(softmax_pkg::alpha_t), .FIFO_DEPTH(FIFO_DEPTH)) u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (alpha_fifo_if.fifo)
  );

endmodule

`default_nettype wire

//--- dv/softmax_tb.sv
// Softmax testbench with reference model, stimulus, output checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module softmax_tb;

  localparam int FIFO_DEPTH   = 16;
  localparam int MAX_NODES    = softmax_pkg::MAX_NODES;
  localparam int RAND_SGS     = 40;
  localparam int BP_SGS       = 12;
  localparam int HOLD_CYCLES  = 400;
  localparam int PAUSE_CYCLES = 100;
  localparam int DRAIN_LIMIT  = 2000;
  // Upper bound on coefficients over all tests
  localparam int MAX_COEFS = 4 + 15 + (RAND_SGS + BP_SGS) * MAX_NODES + 12;
  localparam int WATCHDOG_CYCLES = MAX_COEFS * (softmax_pkg::DIV_LATENCY + 4)
                                   + HOLD_CYCLES + PAUSE_CYCLES + 1000;
  localparam logic [31:0] LFSR_SEED = 32'h6db9_82e6;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                   clk;
  logic                   rst_n;
  logic                   sm_en;
  softmax_pkg::coef_t     coef_in;
  logic                   coef_push;
  logic                   coef_full;
  logic                   num_node_wr;
  softmax_pkg::sg_addr_t  num_node_waddr;
  softmax_pkg::node_cnt_t num_node_wdata;
  softmax_pkg::alpha_t    alpha_out;
  logic                   alpha_empty;
  logic                   alpha_pop;

  softmax_pkg::alpha_t    exp_q [$];
  softmax_pkg::coef_t     sg_coefs [MAX_NODES];
  softmax_pkg::sg_addr_t  sg_next;
  logic [31:0]            lfsr;
  logic                   hold_pops;
  logic                   saw_full;
  string                  test_name;
  int                     err_count;
  int                     total_checks;
  int                     test_count;
  int                     test_errs;
  int                     test_checks;
  int                     rcv_count;
  int                     rcv_base;
  int                     push_count;
  int                     push_base;

  softmax_top #(.FIFO_DEPTH(FIFO_DEPTH), .MAX_NODES(MAX_NODES)) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .sm_en          (sm_en),
    .coef_in        (coef_in),
    .coef_push      (coef_push),
    .coef_full      (coef_full),
    .num_node_wr    (num_node_wr),
    .num_node_waddr (num_node_waddr),
    .num_node_wdata (num_node_wdata),
    .alpha_out      (alpha_out),
    .alpha_empty    (alpha_empty),
    .alpha_pop      (alpha_pop)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // ====================
  // Random numbers and reference model
  // ====================
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return r;
  endfunction

  // floor(2^e * 2^15 / sum)
  function automatic softmax_pkg::alpha_t ref_alpha(input softmax_pkg::coef_t e,
                                                    input logic [31:0] sum);
    logic [63:0] num;
    num = 64'd32768 << e;
    return softmax_pkg::alpha_t'(num / 64'(sum));
  endfunction

  // ====================
  // Checks and bookkeeping
  // ====================
  task automatic check_alpha(input string name, input softmax_pkg::alpha_t expected,
                             input softmax_pkg::alpha_t actual);
    total_checks++;
    test_checks++;
    if (actual !== expected) begin
      $display("FAIL %s: alpha %0d expected %h actual %h", name, rcv_count, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic expected,
                            input logic actual);
    total_checks++;
    test_checks++;
    if (actual !== expected) begin
      $display("FAIL %s: %s expected %b actual %b", name, what, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int expected,
                             input int actual);
    total_checks++;
    test_checks++;
    if (actual != expected) begin
      $display("FAIL %s: %s expected %0d actual %0d", name, what, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errs   = 0;
    test_checks = 0;
    rcv_base    = rcv_count;
    push_base   = push_count;
  endtask

  task automatic finish_test();
    test_count++;
    $display("%-14s %s, %0d checks, %0d errors", test_name,
             (test_errs == 0) ? "passed" : "failed", test_checks, test_errs);
  endtask

  // ====================
  // Stimulus, all called 2 ns after a rising edge
  // ====================
  task automatic write_node_count(input softmax_pkg::sg_addr_t addr, input int n);
    num_node_wr    = 1'b1;
    num_node_waddr = addr;
    num_node_wdata = softmax_pkg::node_cnt_t'(n);
    @(posedge clk);
    #2;
    num_node_wr = 1'b0;
  endtask

  task automatic push_coef(input softmax_pkg::coef_t e);
    while (coef_full) begin
      saw_full = 1'b1;
      @(posedge clk);
      #2;
    end
    coef_in   = e;
    coef_push = 1'b1;
    @(posedge clk);
    #2;
    coef_push = 1'b0;
    push_count++;
  endtask

  // Sends sg_coefs[0 .. n-1] as one subgraph
  task automatic send_subgraph(input int n);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < n; i++) begin
      sum += 32'd1 << sg_coefs[i];
    end
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(ref_alpha(sg_coefs[i], sum));
    end
    write_node_count(sg_next, n);
    sg_next = sg_next + 1'b1;
    for (int i = 0; i < n; i++) begin
      push_coef(sg_coefs[i]);
    end
  endtask

  task automatic send_random(input int sgs, input int base, input int bits);
    int n;
    for (int s = 0; s < sgs; s++) begin
      n = base + int'(take_bits(bits));
      for (int i = 0; i < n; i++) begin
        sg_coefs[i] = softmax_pkg::coef_t'(take_bits(4));
      end
      send_subgraph(n);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || !alpha_empty) && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (cycles >= DRAIN_LIMIT) begin
      $display("ERROR %s: %0d alphas never arrived", test_name, exp_q.size());
      err_count++;
      test_errs++;
    end
  endtask

  // Output side, pops whenever an alpha waits unless held
  initial begin
    alpha_pop = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (rst_n && !alpha_empty && !hold_pops) begin
        if (exp_q.size() == 0) begin
          $display("ERROR %s: alpha %h arrived with none expected", test_name, alpha_out);
          err_count++;
          test_errs++;
        end else begin
          check_alpha(test_name, exp_q.pop_front(), alpha_out);
        end
        rcv_count++;
        alpha_pop = 1'b1;
      end else begin
        alpha_pop = 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ====================
  // Test sequence
  // ====================
  initial begin
    rst_n          = 1'b0;
    sm_en          = 1'b0;
    coef_in        = '0;
    coef_push      = 1'b0;
    num_node_wr    = 1'b0;
    num_node_waddr = '0;
    num_node_wdata = '0;
    hold_pops      = 1'b0;
    saw_full       = 1'b0;
    sg_next        = '0;
    lfsr           = LFSR_SEED;
    err_count      = 0;
    total_checks   = 0;
    test_count     = 0;
    rcv_count      = 0;
    push_count     = 0;
    test_name      = "reset";
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    start_test("reset");
    check_flag(test_name, "alpha_empty", 1'b1, alpha_empty);
    check_flag(test_name, "coef_full", 1'b0, coef_full);
    finish_test();
    sm_en = 1'b1;

    // Every single-node subgraph gives exactly 1.0
    start_test("single_node");
    send_random(4, 1, 0);
    wait_drain();
    finish_test();

    start_test("uniform");
    for (int k = 0; k < 3; k++) begin
      sg_coefs[0] = softmax_pkg::coef_t'(take_bits(4));
      for (int i = 1; i < 2 + 3 * k; i++) begin
        sg_coefs[i] = sg_coefs[0];
      end
      send_subgraph(2 + 3 * k);
    end
    wait_drain();
    finish_test();

    start_test("random");
    send_random(RAND_SGS, 1, 3);
    wait_drain();
    check_count(test_name, "alphas", push_count - push_base, rcv_count - rcv_base);
    finish_test();

    // Output held until the stall reaches the input FIFO
    start_test("backpressure");
    hold_pops = 1'b1;
    saw_full  = 1'b0;
    fork
      send_random(BP_SGS, 5, 2);
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
        check_flag(test_name, "alpha_empty during hold", 1'b0, alpha_empty);
        hold_pops = 1'b0;
      end
    join
    wait_drain();
    check_flag(test_name, "coef_full seen", 1'b1, saw_full);
    check_count(test_name, "alphas", push_count - push_base, rcv_count - rcv_base);
    finish_test();

    start_test("pause");
    sm_en = 1'b0;
    send_random(3, 4, 0);
    repeat (PAUSE_CYCLES) @(posedge clk);
    #2;
    check_flag(test_name, "alpha_empty while paused", 1'b1, alpha_empty);
    check_count(test_name, "alphas while paused", 0, rcv_count - rcv_base);
    sm_en = 1'b1;
    wait_drain();
    check_count(test_name, "alphas after release", 12, rcv_count - rcv_base);
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, total_checks, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- softmax.f
source/softmax_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/node_count_ram.sv
source/fxp_div_pipe.sv
source/softmax.sv
source/softmax_top.sv
dv/softmax_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the softmax testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f softmax.f --top-module softmax_tb -o softmax_sim

output=$(./obj_dir/softmax_sim || true)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
